// File: id_stim.txt
# F addr instr fu op rd rs1 rs2 imm is_compressed illegal is_ctrl_flow name (all hex)
# fu 0 none 1 alu 2 branch 3 load 4 store 5 jump, H n holds the next ack, X flushes
# --- RV32I base opcodes
F 80000000 123452b7 1 5 05 00 00 12345000 0 0 0 lui
F 80000004 fffff397 1 7 07 00 00 fffff000 0 0 0 auipc
F 80000008 ff9ff0ef 5 7 01 00 00 fffffff8 0 0 1 jal
F 8000000c ffc08167 5 0 02 01 00 fffffffc 0 0 1 jalr
F 80000010 00208863 2 0 00 01 02 00000010 0 0 1 beq
F 80000014 fe4198e3 2 1 00 03 04 fffffff0 0 0 1 bne
F 80000018 ff412503 3 2 0a 02 00 fffffff4 0 0 0 lw
F 8000001c 02b12223 4 2 00 02 0b 00000024 0 0 0 sw
F 80000020 fff28313 1 0 06 05 00 ffffffff 0 0 0 addi
F 80000024 002081b3 1 0 03 01 02 00000000 0 0 0 add
F 80000028 40730233 1 8 04 06 07 00000000 0 0 0 sub

# --- Compressed forms next to their 32-bit equivalents
F 8000002c 00001475 1 0 08 08 00 fffffffd 1 0 0 c_addi
F 8000002e ffd40413 1 0 08 08 00 fffffffd 0 0 0 addi_equiv
F 80000032 00004495 1 0 09 00 00 00000005 1 0 0 c_li
F 80000034 00500493 1 0 09 00 00 00000005 0 0 0 li_equiv
F 80000038 0000852e 1 0 0a 00 0b 00000000 1 0 0 c_mv
F 8000003a 00b00533 1 0 0a 00 0b 00000000 0 0 0 mv_equiv
F 8000003e 00009636 1 0 0c 0c 0d 00000000 1 0 0 c_add
F 80000040 00d60633 1 0 0c 0c 0d 00000000 0 0 0 add_equiv

# --- Illegal encodings
F 80000044 00004398 0 0 00 00 00 00000000 1 1 0 c_lw_illegal
F 80000046 00008082 0 0 00 00 00 00000000 1 1 0 c_jr_illegal
F 80000048 0ff0000f 0 0 00 00 00 00000000 0 1 0 fence_illegal
F 8000004c 027302b3 0 0 00 00 00 00000000 0 1 0 mul_illegal

# --- Back-pressure, later entries wait in fetch
H 6
F 80000100 00100093 1 0 01 00 00 00000001 0 0 0 hold_first
F 80000104 00200113 1 0 02 00 00 00000002 0 0 0 hold_second
F 80000108 00308193 1 0 03 01 00 00000003 0 0 0 hold_third
H 3
F 8000010c 00004495 1 0 09 00 00 00000005 1 0 0 hold_compressed

# --- Flush of a held entry
F 80000110 00a00513 1 0 0a 00 00 0000000a 0 0 0 flush_victim
X
F 80000114 fff00593 1 0 0b 00 00 ffffffff 0 0 0 after_flush
F 80000118 00208863 2 0 00 01 02 00000010 0 0 1 after_flush_beq

// File: tb.f
+incdir+.
id_pkg.sv
rvc_expander.sv
instr_decoder.sv
issue_reg.sv
id_stage.sv
tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_id_stage
FILELIST  := tb.f

SOURCES   := $(shell grep -v '^+' $(FILELIST)) id_cfg.svh
SIM       := obj_dir/V$(TOP)
LOG       := sim.log
STIM      := id_stim.txt

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when the file list or a source changes
$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM) $(STIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_id_stage.sv
// Testbench for the instruction decode stage
// Replays the stimulus file: sends fetch entries, checks the decoded issue
// entries, applies back-pressure on acknowledge and flushes held entries

module tb_id_stage;
  import id_pkg::*;

  localparam int TIMEOUT = 100;

  logic              clk_i;
  logic              rst_ni;
  logic              flush_i;
  fetch_entry_t      fetch_entry_i;
  logic              fetch_valid_i;
  logic              fetch_ready_o;
  scoreboard_entry_t issue_entry_o;
  logic              issue_valid_o;
  logic              issue_ack_i;

  // Expected entries in issue order, with test name and extra ack delay
  scoreboard_entry_t exp_q[$];
  logic [127:0]      name_q[$];
  int                hold_q[$];

  scoreboard_entry_t snapshot;
  scoreboard_entry_t nxt_exp;
  logic [127:0]      nxt_name;
  int                nxt_hold;
  fetch_entry_t      drv_entry;
  logic              drv_valid;
  logic              front_checked;
  int                front_errs;
  int                gap_left;
  int                err_count;
  int                tests_pass;
  int                tests_fail;
  logic              timed_out;
  int                seed = 79;

  id_stage i_id_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_entry_i (fetch_entry_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .issue_entry_o (issue_entry_o),
    .issue_valid_o (issue_valid_o),
    .issue_ack_i   (issue_ack_i)
  );

  always #2 clk_i = ~clk_i;

  // ------------------------------
  // Checking helpers
  // ------------------------------
  task automatic check_field(input string field, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, field, got, exp);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input logic ok);
    if (ok) tests_pass++;
    else tests_fail++;
    $display("Test %0d %0s: %0s", tests_pass + tests_fail, name, ok ? "passed" : "FAILED");
  endtask

  // Compare the entry on the issue port with the oldest expected one
  task automatic check_front();
    scoreboard_entry_t e;
    int                rnd;
    e = exp_q[0];
    front_errs = err_count;
    check_field("pc", issue_entry_o.pc, e.pc);
    check_field("fu", 32'(issue_entry_o.fu), 32'(e.fu));
    check_field("op", 32'(issue_entry_o.op), 32'(e.op));
    check_field("rd", 32'(issue_entry_o.rd), 32'(e.rd));
    check_field("rs1", 32'(issue_entry_o.rs1), 32'(e.rs1));
    check_field("rs2", 32'(issue_entry_o.rs2), 32'(e.rs2));
    check_field("imm", issue_entry_o.imm, e.imm);
    check_field("orig_instr", issue_entry_o.orig_instr, e.orig_instr);
    check_field("is_compressed", 32'(issue_entry_o.is_compressed), 32'(e.is_compressed));
    check_field("illegal", 32'(issue_entry_o.illegal), 32'(e.illegal));
    check_field("is_ctrl_flow", 32'(issue_entry_o.is_ctrl_flow), 32'(e.is_ctrl_flow));
    front_checked = 1'b1;
    snapshot = issue_entry_o;
    rnd = $random(seed);
    gap_left = hold_q[0] + (rnd & 3);
  endtask

  task automatic retire_front(input string how);
    report_test($sformatf("%0s (%0s)", name_q[0], how), err_count == front_errs);
    void'(exp_q.pop_front());
    void'(name_q.pop_front());
    void'(hold_q.pop_front());
    front_checked = 1'b0;
  endtask

  // ------------------------------
  // One clock cycle, entered and left 1 unit after a rising edge
  // ------------------------------
  task automatic step_cycle(input logic no_ack, output logic sent);
    logic ack;
    ack = 1'b0;
    if (issue_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("[ERROR] %0t: issue_valid_o high with no entry outstanding", $time);
        err_count++;
      end else begin
        if (!front_checked) check_front();
        else if (issue_entry_o !== snapshot) begin
          $display("[ERROR] %0t: issue_entry_o changed while not acknowledged", $time);
          err_count++;
        end
        if (gap_left == 0 && !no_ack) ack = 1'b1;
        else if (gap_left > 0) gap_left--;
      end
    end
    issue_ack_i = ack;
    fetch_valid_i = drv_valid;
    fetch_entry_i = drv_entry;
    #1;
    // Ready when the slot is free or its entry leaves on this edge
    if (fetch_ready_o !== (!issue_valid_o || ack)) begin
      $display("[ERROR] %0t: fetch_ready_o is %b, expected %b", $time, fetch_ready_o,
               !issue_valid_o || ack);
      err_count++;
    end
    sent = drv_valid && fetch_ready_o;
    @(posedge clk_i);
    #1;
    if (ack) retire_front("issued");
    if (sent) begin
      exp_q.push_back(nxt_exp);
      name_q.push_back(nxt_name);
      hold_q.push_back(nxt_hold);
      nxt_hold = 0;
    end
  endtask

  task automatic send_entry();
    int   waited;
    logic sent;
    waited = 0;
    sent = 1'b0;
    drv_valid = 1'b1;
    while (!sent && !timed_out) begin
      step_cycle(1'b0, sent);
      waited++;
      if (!sent && waited >= TIMEOUT) begin
        $display("Timeout: fetch_ready_o stayed low for %0d cycles", TIMEOUT);
        timed_out = 1'b1;
      end
    end
    drv_valid = 1'b0;
  endtask

  // Flush the entry held in the issue register
  task automatic flush_held();
    int   waited;
    int   base;
    logic sent;
    waited = 0;
    while (!issue_valid_o && !timed_out) begin
      step_cycle(1'b1, sent);
      waited++;
      if (!issue_valid_o && waited >= TIMEOUT) begin
        $display("Timeout: no entry became valid to flush within %0d cycles", TIMEOUT);
        timed_out = 1'b1;
      end
    end
    if (!timed_out) begin
      if (exp_q.size() > 0 && !front_checked) check_front();
      base = err_count;
      issue_ack_i = 1'b0;
      fetch_valid_i = 1'b0;
      flush_i = 1'b1;
      @(posedge clk_i);
      #1;
      flush_i = 1'b0;
      if (issue_valid_o !== 1'b0) begin
        $display("[ERROR] %0t: issue_valid_o still high after flush", $time);
        err_count++;
      end
      if (exp_q.size() > 0) retire_front("flushed");
      report_test("flush", err_count == base);
    end
  endtask

  task automatic drain();
    int   waited;
    logic sent;
    waited = 0;
    while (exp_q.size() > 0 && !timed_out) begin
      step_cycle(1'b0, sent);
      waited++;
      if (exp_q.size() > 0 && waited >= TIMEOUT) begin
        $display("Timeout: last entries did not leave the issue port in %0d cycles", TIMEOUT);
        timed_out = 1'b1;
      end
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int           fd;
    int           n;
    string        line;
    logic [7:0]   cmd;
    logic [31:0]  v [11];
    logic [127:0] name;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_entry_i = '0;
    issue_ack_i = 1'b0;
    drv_valid = 1'b0;
    drv_entry = '0;
    nxt_hold = 0;
    front_checked = 1'b0;
    err_count = 0;
    tests_pass = 0;
    tests_fail = 0;
    timed_out = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    n = err_count;
    if (issue_valid_o !== 1'b0) begin
      $display("[ERROR] %0t: issue_valid_o is %b after reset", $time, issue_valid_o);
      err_count++;
    end
    if (fetch_ready_o !== 1'b1) begin
      $display("[ERROR] %0t: fetch_ready_o is %b after reset", $time, fetch_ready_o);
      err_count++;
    end
    report_test("reset", err_count == n);

    fd = $fopen("id_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file id_stim.txt");
      err_count++;
    end else begin
      while (!timed_out && $fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c", cmd);
          case (cmd)
            "F": begin
              n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h %s", cmd, v[0], v[1],
                          v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], name);
              nxt_exp = '0;
              nxt_exp.pc = v[0];
              nxt_exp.orig_instr = v[1];
              nxt_exp.fu = fu_t'(v[2][2:0]);
              nxt_exp.op = v[3][3:0];
              nxt_exp.rd = v[4][4:0];
              nxt_exp.rs1 = v[5][4:0];
              nxt_exp.rs2 = v[6][4:0];
              nxt_exp.imm = v[7];
              nxt_exp.is_compressed = v[8][0];
              nxt_exp.illegal = v[9][0];
              nxt_exp.is_ctrl_flow = v[10][0];
              nxt_name = name;
              drv_entry.address = v[0];
              drv_entry.instruction = v[1];
              if (n != 13) begin
                $display("Malformed stimulus line: %0s", line);
                err_count++;
              end else begin
                send_entry();
              end
            end
            "H": begin
              n = $sscanf(line, "%c %h", cmd, v[0]);
              nxt_hold = v[0];
            end
            "X": flush_held();
            default: begin
              $display("Unknown stimulus command: %0s", line);
              err_count++;
            end
          endcase
        end
      end
      $fclose(fd);
      drain();
    end

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d", tests_pass, tests_fail,
             err_count);
    if (err_count == 0 && tests_fail == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: id_stage.sv
// Instruction decode stage, single issue port
// Fetch entry is expanded, decoded and held in the ID/issue register

module id_stage (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  // Fetch side
  input  id_pkg::fetch_entry_t      fetch_entry_i,
  input  logic                      fetch_valid_i,
  output logic                      fetch_ready_o,
  // Issue side
  output id_pkg::scoreboard_entry_t issue_entry_o,
  output logic                      issue_valid_o,
  input  logic                      issue_ack_i
);
  import id_pkg::*;

  expanded_t         expanded;
  scoreboard_entry_t decoded;

  // ------------------------------
  // Compressed expansion
  // ------------------------------
  rvc_expander i_rvc_expander (
    .instr_i    (fetch_entry_i.instruction),
    .expanded_o (expanded)
  );

  // ------------------------------
  // Decode
  // ------------------------------
  instr_decoder i_instr_decoder (
    .pc_i         (fetch_entry_i.address),
    .expanded_i   (expanded),
    .orig_instr_i (fetch_entry_i.instruction),
    .entry_o      (decoded)
  );

  // ------------------------------
  // ID/issue register
  // ------------------------------
  issue_reg i_issue_reg (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .entry_i       (decoded),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .issue_ack_i   (issue_ack_i),
    .flush_i       (flush_i),
    .issue_entry_o (issue_entry_o),
    .issue_valid_o (issue_valid_o)
  );

endmodule

// File: issue_reg.sv
// ID/issue pipeline register
// Holds one decoded entry until issue acknowledges it, flush drops it

module issue_reg (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  id_pkg::scoreboard_entry_t entry_i,
  input  logic                      fetch_valid_i,
  output logic                      fetch_ready_o,
  input  logic                      issue_ack_i,
  input  logic                      flush_i,
  output id_pkg::scoreboard_entry_t issue_entry_o,
  output logic                      issue_valid_o
);
  import id_pkg::*;

  logic              valid_q;
  logic              valid_d;
  logic              load;
  scoreboard_entry_t entry_q;

  // Free slot, or the held entry leaves on this edge
  assign fetch_ready_o = !valid_q || issue_ack_i;
  // A transfer coinciding with a flush is dropped
  assign load = fetch_valid_i && fetch_ready_o && !flush_i;

  always_comb begin
    valid_d = valid_q;
    if (issue_ack_i) valid_d = 1'b0;
    if (load) valid_d = 1'b1;
    // Flush wins over everything
    if (flush_i) valid_d = 1'b0;
  end

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) entry_q <= entry_i;
  end

  assign issue_valid_o = valid_q;
  assign issue_entry_o = entry_q;

  // Held entry is stable under back-pressure
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ack_i && !flush_i |=> issue_valid_o && $stable(issue_entry_o))
  else $error("issue_reg: held entry changed or vanished");

  // Issue side may only acknowledge a valid entry
  a_ack_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> issue_valid_o)
  else $error("issue_reg: acknowledge without valid entry");

endmodule

// File: instr_decoder.sv
// RV32I instruction decoder
// Turns an expanded 32-bit instruction into a scoreboard entry with
// functional unit, operation, register indices and immediate

`include "id_cfg.svh"

module instr_decoder (
  input  logic [`ID_XLEN-1:0]       pc_i,
  input  id_pkg::expanded_t         expanded_i,
  input  logic [`ID_ILEN-1:0]       orig_instr_i,
  output id_pkg::scoreboard_entry_t entry_o
);
  import id_pkg::*;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  logic [`ID_ILEN-1:0] instr;
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  imm_fmt_t            imm_fmt;
  fu_t                 fu;
  logic                is_ctrl_flow;
  logic                illegal;
  logic                use_rd;
  logic                use_rs1;
  logic                use_rs2;
  logic [`ID_XLEN-1:0] imm;

  assign instr  = expanded_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // ------------------------------
  // Opcode classification
  // ------------------------------
  always_comb begin
    fu           = FU_NONE;
    imm_fmt      = IMM_NONE;
    is_ctrl_flow = 1'b0;
    illegal      = expanded_i.illegal;
    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        fu      = FU_ALU;
        imm_fmt = IMM_U;
      end
      OPC_JAL: begin
        fu           = FU_JUMP;
        imm_fmt      = IMM_J;
        is_ctrl_flow = 1'b1;
      end
      OPC_JALR: begin
        fu           = FU_JUMP;
        imm_fmt      = IMM_I;
        is_ctrl_flow = 1'b1;
      end
      OPC_BRANCH: begin
        fu           = FU_BRANCH;
        imm_fmt      = IMM_B;
        is_ctrl_flow = 1'b1;
      end
      OPC_LOAD: begin
        fu      = FU_LOAD;
        imm_fmt = IMM_I;
      end
      OPC_STORE: begin
        fu      = FU_STORE;
        imm_fmt = IMM_S;
      end
      OPC_OP_IMM: begin
        fu      = FU_ALU;
        imm_fmt = IMM_I;
      end
      OPC_OP: begin
        fu = FU_ALU;
        // Only base ADD/SUB-style funct7 values, no M extension
        if (funct7 != 7'h00 && funct7 != 7'h20) illegal = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
  end

  // Sign-extended immediate per format
  always_comb begin
    case (imm_fmt)
      IMM_I:   imm = {{20{instr[31]}}, instr[31:20]};
      IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      IMM_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      IMM_U:   imm = {instr[31:12], 12'b0};
      IMM_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  // Register fields a format does not carry stay zero
  assign use_rd  = (imm_fmt != IMM_S) && (imm_fmt != IMM_B);
  assign use_rs1 = (imm_fmt != IMM_U) && (imm_fmt != IMM_J);
  assign use_rs2 = (imm_fmt == IMM_NONE) || (imm_fmt == IMM_S) || (imm_fmt == IMM_B);

  // ------------------------------
  // Entry assembly
  // ------------------------------
  always_comb begin
    entry_o               = '0;
    entry_o.pc            = pc_i;
    entry_o.orig_instr    = orig_instr_i;
    entry_o.is_compressed = expanded_i.is_compressed;
    entry_o.illegal       = illegal;
    if (!illegal) begin
      entry_o.fu           = fu;
      entry_o.op           = (opcode == OPC_OP) ? {funct7[5], funct3} : {1'b0, funct3};
      entry_o.rd           = use_rd ? instr[11:7] : '0;
      entry_o.rs1          = use_rs1 ? instr[19:15] : '0;
      entry_o.rs2          = use_rs2 ? instr[24:20] : '0;
      entry_o.imm          = imm;
      entry_o.is_ctrl_flow = is_ctrl_flow;
    end
  end

endmodule

// File: rvc_expander.sv
// Compressed instruction expander
// Rebuilds C.ADDI, C.LI, C.MV and C.ADD as 32-bit ADDI/ADD, passes
// full-width instructions through and flags other compressed encodings

`include "id_cfg.svh"

module rvc_expander (
  input  logic [`ID_ILEN-1:0] instr_i,
  output id_pkg::expanded_t   expanded_o
);

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  logic [1:0]  quadrant;
  logic [2:0]  funct3;
  logic [4:0]  rd_rs1;
  logic [4:0]  rs2;
  logic [11:0] imm6_sext;

  // ------------------------------
  // Compressed fields
  // ------------------------------
  assign quadrant  = instr_i[1:0];
  assign funct3    = instr_i[15:13];
  assign rd_rs1    = instr_i[11:7];
  assign rs2       = instr_i[6:2];
  // CI-format 6-bit immediate, sign bit in instr[12]
  assign imm6_sext = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};

  // ------------------------------
  // Expansion
  // ------------------------------
  always_comb begin
    expanded_o.instr         = instr_i;
    expanded_o.is_compressed = 1'b0;
    expanded_o.illegal       = 1'b0;

    if (quadrant != 2'b11) begin
      expanded_o.is_compressed = 1'b1;
      expanded_o.instr         = '0;
      expanded_o.illegal       = 1'b1;

      if (quadrant == 2'b01 && funct3 == 3'b000) begin
        // C.ADDI -> addi rd, rd, imm
        expanded_o.instr   = {imm6_sext, rd_rs1, 3'b000, rd_rs1, OPC_OP_IMM};
        expanded_o.illegal = 1'b0;
      end else if (quadrant == 2'b01 && funct3 == 3'b010) begin
        // C.LI -> addi rd, x0, imm
        expanded_o.instr   = {imm6_sext, 5'd0, 3'b000, rd_rs1, OPC_OP_IMM};
        expanded_o.illegal = 1'b0;
      end else if (quadrant == 2'b10 && funct3 == 3'b100 && rs2 != 5'd0) begin
        // rs2 of zero would be C.JR / C.JALR / C.EBREAK, left illegal
        if (instr_i[12]) begin
          // C.ADD -> add rd, rd, rs2
          expanded_o.instr = {7'b0, rs2, rd_rs1, 3'b000, rd_rs1, OPC_OP};
        end else begin
          // C.MV -> add rd, x0, rs2
          expanded_o.instr = {7'b0, rs2, 5'd0, 3'b000, rd_rs1, OPC_OP};
        end
        expanded_o.illegal = 1'b0;
      end
    end

    // Any legal result must be a full-width encoding
    assert ($isunknown(instr_i) || expanded_o.illegal ||
            expanded_o.instr[1:0] == 2'b11)
    else $error("rvc_expander: legal output without 32-bit opcode");
  end

endmodule

// File: id_pkg.sv
// Decode stage package
// Fetch entry, scoreboard entry and decoder classification types

`include "id_cfg.svh"

package id_pkg;

  // Entry handed over by fetch
  typedef struct packed {
    logic [`ID_XLEN-1:0] address;
    logic [`ID_ILEN-1:0] instruction;
  } fetch_entry_t;

  // Functional unit that executes the instruction
  typedef enum logic [2:0] {
    FU_NONE,
    FU_ALU,
    FU_BRANCH,
    FU_LOAD,
    FU_STORE,
    FU_JUMP
  } fu_t;

  // Immediate layout, IMM_NONE covers R-type and illegal encodings
  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_fmt_t;

  // Decoded instruction as held in the ID/issue register
  typedef struct packed {
    logic [`ID_XLEN-1:0]  pc;
    fu_t                  fu;
    logic [3:0]           op;
    logic [`ID_REG_W-1:0] rd;
    logic [`ID_REG_W-1:0] rs1;
    logic [`ID_REG_W-1:0] rs2;
    logic [`ID_XLEN-1:0]  imm;
    logic [`ID_ILEN-1:0]  orig_instr;
    logic                 is_compressed;
    logic                 illegal;
    logic                 is_ctrl_flow;
  } scoreboard_entry_t;

  // Output of the compressed expander
  typedef struct packed {
    logic [`ID_ILEN-1:0] instr;
    logic                is_compressed;
    logic                illegal;
  } expanded_t;

endpackage

// File: id_cfg.svh
// Decode stage configuration
// Instruction, address and register index widths shared by package and RTL

`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// ------------------------------
// Datapath widths
// ------------------------------

// Address and immediate width
`define ID_XLEN 32

// Full instruction width, compressed ones use the low half
`define ID_ILEN 32

// Architectural register index width
`define ID_REG_W 5

`endif
